// ==== rtl/fp_exponent.sv ====
// --------------------
// exponent datapath
// both exponents, compare, step and range flag
// --------------------
`timescale 1ns/1ps
`include "fpu_params.svh"

module fp_exponent (
	input  logic got_fp,
	input  logic _0_f,
	input  logic strob1,
	input  logic step_start,
	input  fpu_pkg::fp_word_u mem_data,
	input  logic m_load_word,
	input  logic [1:0] lp_word,
	input  logic t_from_m,
	input  logic t_shift_r,
	input  logic m_shift_r,
	input  logic m_clear,
	input  logic t_fix_ovf,
	input  logic t_norm_l,
	input  logic t_zero,
	output logic acc_lt,
	output logic exp_eq,
	output logic exp_far,
	output logic [`FP_EXP_W-1:0] acc_exp,
	output logic ovf
);

	logic [`FP_EXP_W-1:0] exp_t;
	logic [`FP_EXP_W-1:0] exp_m;
	// sign extended by one bit
	logic [`FP_EXP_W:0] t_wide;
	logic [`FP_EXP_W:0] m_wide;
	logic [`FP_EXP_W:0] diff;
	logic [`FP_EXP_W:0] diff_abs;
	logic [`FP_EXP_W:0] t_inc;
	logic [`FP_EXP_W:0] t_dec;
	logic [`FP_EXP_W:0] m_inc;
	logic range_err;

	// --------------------
	// compare
	// --------------------

	assign t_wide = {exp_t[`FP_EXP_W-1], exp_t};
	assign m_wide = {exp_m[`FP_EXP_W-1], exp_m};
	assign diff = t_wide - m_wide;
	assign diff_abs = diff[`FP_EXP_W] ? -diff : diff;

	assign acc_lt = diff[`FP_EXP_W];
	assign exp_eq = (diff == '0);
	// every mantissa bit would shift out
	assign exp_far = (diff_abs > `FP_MANT_W - 1);

	assign t_inc = t_wide + 1'b1;
	assign t_dec = t_wide - 1'b1;
	assign m_inc = m_wide + 1'b1;

	// result leaves the signed range when the two top bits differ
	assign range_err = (t_shift_r & ~exp_far & (t_inc[`FP_EXP_W] ^ t_inc[`FP_EXP_W-1]))
		| (t_fix_ovf & (t_inc[`FP_EXP_W] ^ t_inc[`FP_EXP_W-1]))
		| (t_norm_l & ~t_zero & (t_dec[`FP_EXP_W] ^ t_dec[`FP_EXP_W-1]))
		| (m_shift_r & ~m_clear & (m_inc[`FP_EXP_W] ^ m_inc[`FP_EXP_W-1]));

	// --------------------
	// registers
	// --------------------

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			exp_t <= '0;
		end else if (strob1) begin
			if (t_from_m)
				exp_t <= exp_m;
			else if (t_shift_r)
				exp_t <= exp_far ? exp_m : t_inc[`FP_EXP_W-1:0];
			else if (t_fix_ovf)
				exp_t <= t_inc[`FP_EXP_W-1:0];
			else if (t_norm_l)
				// zero mantissa gets exponent zero
				exp_t <= t_zero ? '0 : t_dec[`FP_EXP_W-1:0];
		end
	end

	always_ff @(posedge got_fp) begin
		if (strob1) begin
			if (m_load_word && lp_word == 2'd2)
				exp_m <= mem_data.w2.exp;
			else if (m_clear)
				exp_m <= exp_t;
			else if (m_shift_r)
				exp_m <= m_inc[`FP_EXP_W-1:0];
		end
	end

	// sticky until the next operation starts
	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f)
			ovf <= 1'b0;
		else if (step_start)
			ovf <= 1'b0;
		else if (strob1 && range_err)
			ovf <= 1'b1;
	end

	assign acc_exp = exp_t;

endmodule

// ==== rtl/fp_mantissa.sv ====
// --------------------
// mantissa datapath
// t accumulator, m operand, adder and shifters
// --------------------
`timescale 1ns/1ps
`include "fpu_params.svh"

module fp_mantissa (
	input  logic got_fp,
	input  logic _0_f,
	input  logic strob1,
	input  fpu_pkg::fp_word_u mem_data,
	input  logic [1:0] lp_word,
	input  logic m_load_word,
	input  logic t_from_m,
	input  logic t_shift_r,
	input  logic m_shift_r,
	input  logic m_clear,
	input  logic t_clear,
	input  logic t_add,
	input  logic t_sub,
	input  logic t_norm_l,
	input  logic t_fix_ovf,
	output logic t_zero,
	output logic t_normal,
	output logic add_ovf,
	output logic [`FP_MANT_W-1:0] acc_mant
);

	// accumulator
	logic [`FP_MANT_W-1:0] t_mant;
	// operand
	logic [`FP_MANT_W-1:0] m_mant;
	// one guard bit above the sign
	logic [`FP_MANT_W:0] t_ext;
	logic [`FP_MANT_W:0] m_ext;
	logic [`FP_MANT_W:0] sum;

	// --------------------
	// adder
	// --------------------

	assign t_ext = {t_mant[`FP_MANT_W-1], t_mant};
	assign m_ext = {m_mant[`FP_MANT_W-1], m_mant};
	assign sum = t_sub ? (t_ext - m_ext) : (t_ext + m_ext);

	// guard and sign disagree
	assign add_ovf = sum[`FP_MANT_W] ^ sum[`FP_MANT_W-1];

	// status for the sequencer
	assign t_zero = (t_mant == '0);
	assign t_normal = t_mant[`FP_MANT_W-1] ^ t_mant[`FP_MANT_W-2];

	// --------------------
	// t register
	// --------------------

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			t_mant <= '0;
		end else if (strob1) begin
			if (t_clear)
				t_mant <= '0;
			else if (t_shift_r)
				t_mant <= {t_mant[`FP_MANT_W-1], t_mant[`FP_MANT_W-1:1]};
			else if (t_from_m)
				t_mant <= m_mant;
			else if (t_add || t_sub)
				// on overflow keep the guard bit as the true sign
				t_mant <= t_fix_ovf ? sum[`FP_MANT_W:1] : sum[`FP_MANT_W-1:0];
			else if (t_norm_l)
				t_mant <= {t_mant[`FP_MANT_W-2:0], 1'b0};
		end
	end

	assign acc_mant = t_mant;

	// --------------------
	// m register
	// --------------------

	always_ff @(posedge got_fp) begin
		if (strob1) begin
			if (m_load_word) begin
				// lp picks which slice the word fills
				case (lp_word)
					2'd0:
						m_mant[`FP_MANT_W-1 -: `FP_WORD_W] <= mem_data.raw;
					2'd1:
						m_mant[`FP_MANT_W-1-`FP_WORD_W -: `FP_WORD_W] <= mem_data.raw;
					default:
						m_mant[`FP_WORD_W-`FP_EXP_W-1:0] <= mem_data.w2.m_lo;
				endcase
			end else if (m_clear) begin
				m_mant <= '0;
			end else if (m_shift_r) begin
				m_mant <= {m_mant[`FP_MANT_W-1], m_mant[`FP_MANT_W-1:1]};
			end
		end
	end

endmodule

// ==== rtl/fps.sv ====
// --------------------
// fps control sequencer
// start delay, one-hot steps, lp word counter
// datapath control decode
// --------------------
`timescale 1ns/1ps
`include "fpu_params.svh"

module fps (
	input  logic got_fp,
	input  logic _0_f,
	input  logic efp,
	input  fpu_pkg::fp_op_e op,
	input  logic [`FP_ADDR_W-1:0] addr,
	input  logic t_zero,
	input  logic t_normal,
	input  logic add_ovf,
	input  logic acc_lt,
	input  logic exp_eq,
	input  logic exp_far,
	input  logic got_step,
	output logic busy,
	output logic ekc_fp,
	output logic [`FP_ADDR_W-1:0] mem_addr,
	output fpu_pkg::fp_state_e step_state,
	output logic step_start,
	output logic [1:0] lp_word,
	output logic m_load_word,
	output logic t_from_m,
	output logic t_shift_r,
	output logic m_shift_r,
	output logic m_clear,
	output logic t_clear,
	output logic t_add,
	output logic t_sub,
	output logic t_norm_l,
	output logic t_fix_ovf
);

	fpu_pkg::fp_state_e state;
	fpu_pkg::fp_state_e state_nxt;
	// latched request
	fpu_pkg::fp_op_e op_q;
	logic [`FP_ADDR_W-1:0] addr_q;
	// start delay line
	logic [1:0] start_dly;
	logic accept;
	// word counter
	logic [1:0] lp;
	logic lp_last;
	// single step flags
	logic st_idle;
	logic st_read;
	logic st_loadt;
	logic st_align;
	logic st_add;
	logic st_norm;
	logic st_done;
	logic align_go;
	logic norm_end;

	assign st_idle  = (state == fpu_pkg::ST_IDLE);
	assign st_read  = (state == fpu_pkg::ST_READ);
	assign st_loadt = (state == fpu_pkg::ST_LOADT);
	assign st_align = (state == fpu_pkg::ST_ALIGN);
	assign st_add   = (state == fpu_pkg::ST_ADD);
	assign st_norm  = (state == fpu_pkg::ST_NORM);
	assign st_done  = (state == fpu_pkg::ST_DONE);

	// --------------------
	// start
	// --------------------

	// efp only taken from an idle unit
	assign accept = efp & ~busy & st_idle;

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			start_dly <= 2'b00;
			busy <= 1'b0;
		end else begin
			start_dly <= {start_dly[0], accept};
			if (accept)
				busy <= 1'b1;
			else if (got_step && st_norm && norm_end)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge got_fp) begin
		if (accept) begin
			op_q <= op;
			addr_q <= addr;
		end
	end

	// first step entered two cycles after efp is taken
	assign step_start = start_dly[1];

	// --------------------
	// step flip-flops
	// --------------------

	// normalize ends on a normal or zero mantissa
	assign norm_end = t_normal | t_zero;
	assign lp_last = (lp == 2'd2);

	always_comb begin
		state_nxt = state;
		case (state)
			fpu_pkg::ST_IDLE:
				if (step_start)
					state_nxt = (op_q == fpu_pkg::OP_NORM) ? fpu_pkg::ST_NORM : fpu_pkg::ST_READ;
			fpu_pkg::ST_READ:
				if (got_step && lp_last)
					state_nxt = (op_q == fpu_pkg::OP_LOAD) ? fpu_pkg::ST_LOADT : fpu_pkg::ST_ALIGN;
			fpu_pkg::ST_LOADT:
				if (got_step)
					state_nxt = fpu_pkg::ST_NORM;
			fpu_pkg::ST_ALIGN:
				// repeated until exponents meet
				if (got_step && exp_eq)
					state_nxt = fpu_pkg::ST_ADD;
			fpu_pkg::ST_ADD:
				if (got_step)
					state_nxt = fpu_pkg::ST_NORM;
			fpu_pkg::ST_NORM:
				if (got_step && norm_end)
					state_nxt = fpu_pkg::ST_DONE;
			fpu_pkg::ST_DONE:
				state_nxt = fpu_pkg::ST_IDLE;
			default:
				state_nxt = fpu_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f)
			state <= fpu_pkg::ST_IDLE;
		else
			state <= state_nxt;
	end

	assign step_state = state;

	// done pulse lasts the one done cycle
	assign ekc_fp = st_done;

	// --------------------
	// lp counter
	// --------------------

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f)
			lp <= 2'd0;
		else if (step_start)
			lp <= 2'd0;
		else if (got_step && st_read)
			lp <= lp_last ? 2'd0 : lp + 2'd1;
	end

	assign lp_word = lp;
	assign mem_addr = addr_q + {{(`FP_ADDR_W-2){1'b0}}, lp};

	// --------------------
	// datapath controls
	// --------------------

	assign m_load_word = st_read;
	assign t_from_m = st_loadt;

	// smaller exponent side moves
	assign align_go = st_align & ~exp_eq;
	assign t_shift_r = align_go & acc_lt;
	assign m_shift_r = align_go & ~acc_lt;
	// too far apart, drop the small operand at once
	assign t_clear = t_shift_r & exp_far;
	assign m_clear = m_shift_r & exp_far;

	assign t_add = st_add & (op_q == fpu_pkg::OP_ADD);
	assign t_sub = st_add & (op_q == fpu_pkg::OP_SUB);
	assign t_fix_ovf = st_add & add_ovf;

	// zero also counts as not normal, exponent side clears it
	assign t_norm_l = st_norm & ~t_normal;

	// --------------------
	// checks
	// --------------------

	a_onehot: assert property (
		@(posedge got_fp) disable iff (_0_f)
		$onehot(state)
	);

	a_ekc_pulse: assert property (
		@(posedge got_fp) disable iff (_0_f)
		ekc_fp |=> !ekc_fp
	);

endmodule

// ==== rtl/fps_strobgen.sv ====
// --------------------
// fps strobe generator
// two phases per step, memory read handshake
// --------------------
`timescale 1ns/1ps

module fps_strobgen (
	input  logic got_fp,
	input  logic _0_f,
	input  fpu_pkg::fp_state_e step_state,
	input  logic step_start,
	input  logic ok,
	output logic strob1,
	output logic strob2,
	output logic got_step,
	output logic read_fp
);

	// step is a working one
	logic run;
	// fetch step, strob1 waits for memory
	logic in_read;
	// second phase flag
	logic ph;

	// --------------------
	// step decode
	// --------------------

	assign run = (step_state != fpu_pkg::ST_IDLE) && (step_state != fpu_pkg::ST_DONE);
	assign in_read = (step_state == fpu_pkg::ST_READ);

	// --------------------
	// phases
	// --------------------

	// first phase, held off in a fetch until memory answers
	assign strob1 = run & ~ph & (~in_read | ok);

	// request stays up through the whole first phase of a fetch
	assign read_fp = in_read & ~ph;

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			ph <= 1'b0;
		end else if (step_start) begin
			// new operation starts on phase one
			ph <= 1'b0;
		end else begin
			// strob1 arms phase two, phase two falls back
			ph <= strob1;
		end
	end

	// clear phase
	assign strob2 = ph;

	// sequencer advances on the clear phase edge
	assign got_step = strob2 & run;

	// --------------------
	// checks
	// --------------------

	// memory request is never withdrawn before ok
	a_read_hold: assert property (
		@(posedge got_fp) disable iff (_0_f)
		read_fp && !ok |=> read_fp
	);

	// enable phase is always followed by the clear phase alone
	a_no_overlap: assert property (
		@(posedge got_fp) disable iff (_0_f)
		strob1 |=> strob2 && !strob1
	);

endmodule

// ==== rtl/fpu_params.svh ====
// --------------------
// fpu widths shared by the rtl and the testbench
// --------------------
`ifndef FPU_PARAMS_SVH
`define FPU_PARAMS_SVH

// two's complement fraction
`define FP_MANT_W 40
// signed exponent
`define FP_EXP_W 8
// memory bus
`define FP_WORD_W 16
`define FP_ADDR_W 16

`endif

// ==== rtl/fpu_pkg.sv ====
// --------------------
// fpu types
// operation codes, sequencer steps, operand word views
// --------------------
`include "fpu_params.svh"

package fpu_pkg;

	// cpu operation select
	typedef enum logic [1:0] {
		OP_LOAD = 2'd0,
		OP_ADD  = 2'd1,
		OP_SUB  = 2'd2,
		OP_NORM = 2'd3
	} fp_op_e;

	// one-hot sequencer steps
	typedef enum logic [6:0] {
		ST_IDLE  = 7'b000_0001,
		ST_READ  = 7'b000_0010,
		ST_LOADT = 7'b000_0100,
		ST_ALIGN = 7'b000_1000,
		ST_ADD   = 7'b001_0000,
		ST_NORM  = 7'b010_0000,
		ST_DONE  = 7'b100_0000
	} fp_state_e;

	// third operand word split into mantissa low byte and exponent
	typedef struct packed {
		logic [`FP_WORD_W-`FP_EXP_W-1:0] m_lo;
		logic [`FP_EXP_W-1:0] exp;
	} fp_w2_s;

	// memory word, raw or as the third word
	typedef union packed {
		logic [`FP_WORD_W-1:0] raw;
		fp_w2_s w2;
	} fp_word_u;

endpackage

// ==== rtl/fpu_top.sv ====
// --------------------
// fpu top
// sequencer, strobes and datapath wired together
// --------------------
`timescale 1ns/1ps
`include "fpu_params.svh"

module fpu_top (
	input  logic got_fp,
	input  logic _0_f,
	input  logic efp,
	input  fpu_pkg::fp_op_e op,
	input  logic [`FP_ADDR_W-1:0] addr,
	input  logic ok,
	input  fpu_pkg::fp_word_u mem_data,
	output logic busy,
	output logic ekc_fp,
	output logic read_fp,
	output logic [`FP_ADDR_W-1:0] mem_addr,
	output logic [`FP_MANT_W-1:0] acc_mant,
	output logic [`FP_EXP_W-1:0] acc_exp,
	output logic ovf
);

	// sequencer to strobes
	fpu_pkg::fp_state_e step_state;
	logic step_start;
	logic strob1;
	logic got_step;
	// controls
	logic [1:0] lp_word;
	logic m_load_word;
	logic t_from_m;
	logic t_shift_r;
	logic m_shift_r;
	logic m_clear;
	logic t_clear;
	logic t_add;
	logic t_sub;
	logic t_norm_l;
	logic t_fix_ovf;
	// status
	logic t_zero;
	logic t_normal;
	logic add_ovf;
	logic acc_lt;
	logic exp_eq;
	logic exp_far;

	fps i_fps (
		.got_fp(got_fp),
		._0_f(_0_f),
		.efp(efp),
		.op(op),
		.addr(addr),
		.t_zero(t_zero),
		.t_normal(t_normal),
		.add_ovf(add_ovf),
		.acc_lt(acc_lt),
		.exp_eq(exp_eq),
		.exp_far(exp_far),
		.got_step(got_step),
		.busy(busy),
		.ekc_fp(ekc_fp),
		.mem_addr(mem_addr),
		.step_state(step_state),
		.step_start(step_start),
		.lp_word(lp_word),
		.m_load_word(m_load_word),
		.t_from_m(t_from_m),
		.t_shift_r(t_shift_r),
		.m_shift_r(m_shift_r),
		.m_clear(m_clear),
		.t_clear(t_clear),
		.t_add(t_add),
		.t_sub(t_sub),
		.t_norm_l(t_norm_l),
		.t_fix_ovf(t_fix_ovf)
	);

	// clear phase has no user outside the strobe block
	fps_strobgen i_fps_strobgen (
		.got_fp(got_fp),
		._0_f(_0_f),
		.step_state(step_state),
		.step_start(step_start),
		.ok(ok),
		.strob1(strob1),
		.strob2(),
		.got_step(got_step),
		.read_fp(read_fp)
	);

	fp_mantissa i_fp_mantissa (
		.got_fp(got_fp),
		._0_f(_0_f),
		.strob1(strob1),
		.mem_data(mem_data),
		.lp_word(lp_word),
		.m_load_word(m_load_word),
		.t_from_m(t_from_m),
		.t_shift_r(t_shift_r),
		.m_shift_r(m_shift_r),
		.m_clear(m_clear),
		.t_clear(t_clear),
		.t_add(t_add),
		.t_sub(t_sub),
		.t_norm_l(t_norm_l),
		.t_fix_ovf(t_fix_ovf),
		.t_zero(t_zero),
		.t_normal(t_normal),
		.add_ovf(add_ovf),
		.acc_mant(acc_mant)
	);

	fp_exponent i_fp_exponent (
		.got_fp(got_fp),
		._0_f(_0_f),
		.strob1(strob1),
		.step_start(step_start),
		.mem_data(mem_data),
		.m_load_word(m_load_word),
		.lp_word(lp_word),
		.t_from_m(t_from_m),
		.t_shift_r(t_shift_r),
		.m_shift_r(m_shift_r),
		.m_clear(m_clear),
		.t_fix_ovf(t_fix_ovf),
		.t_norm_l(t_norm_l),
		.t_zero(t_zero),
		.acc_lt(acc_lt),
		.exp_eq(exp_eq),
		.exp_far(exp_far),
		.acc_exp(acc_exp),
		.ovf(ovf)
	);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the fpu testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fpu_tb -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vfpu_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "TESTS PASSED"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== sim.f ====
+incdir+rtl
rtl/fpu_pkg.sv
rtl/fps_strobgen.sv
rtl/fps.sv
rtl/fp_mantissa.sv
rtl/fp_exponent.sv
rtl/fpu_top.sv
sim/fpu_tb.sv

// ==== sim/fpu_tb.sv ====
// --------------------
// fpu testbench
// directed operations checked against a reference model
// --------------------
`timescale 1ns/1ps
`include "fpu_params.svh"

module fpu_tb;

	localparam int MW = `FP_MANT_W;
	localparam int EW = `FP_EXP_W;
	localparam int AW = `FP_ADDR_W;
	localparam int EMAX = (1 << (EW - 1)) - 1;
	localparam int EMIN = -(1 << (EW - 1));
	localparam longint MMAX = (longint'(1) << (MW - 1)) - 1;
	localparam longint MMIN = -(longint'(1) << (MW - 1));
	localparam int RESET_CYCLES = 2;
	localparam int OP_CYCLES = 200;
	localparam int NUM_OPS = 30;
	localparam int IDLE_MARGIN = 50;
	localparam int MEM_WORDS = 256;

	logic got_fp;
	logic _0_f;
	logic efp;
	fpu_pkg::fp_op_e op;
	logic [AW-1:0] addr;
	logic ok;
	fpu_pkg::fp_word_u mem_data;
	logic busy;
	logic ekc_fp;
	logic read_fp;
	logic [AW-1:0] mem_addr;
	logic [MW-1:0] acc_mant;
	logic [EW-1:0] acc_exp;
	logic ovf;

	// memory image and the addresses it served
	logic [`FP_WORD_W-1:0] mem [0:MEM_WORDS-1];
	logic [AW-1:0] addr_log[$];
	// 0 picks a random delay
	int fixed_delay;
	logic [AW-1:0] next_addr;

	// expected accumulator
	logic signed [MW-1:0] ref_mant;
	logic signed [EW-1:0] ref_exp;
	logic ref_ovf;

	fpu_top i_fpu_top (
		.got_fp(got_fp),
		._0_f(_0_f),
		.efp(efp),
		.op(op),
		.addr(addr),
		.ok(ok),
		.mem_data(mem_data),
		.busy(busy),
		.ekc_fp(ekc_fp),
		.read_fp(read_fp),
		.mem_addr(mem_addr),
		.acc_mant(acc_mant),
		.acc_exp(acc_exp),
		.ovf(ovf)
	);

	initial got_fp = 1'b0;
	always #5 got_fp = ~got_fp;

	// --------------------
	// failure reporting
	// --------------------

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_val(input string name, input logic [63:0] got,
			input logic [63:0] want);
		if (got !== want) begin
			$display("error %s: got 0x%0h, expected 0x%0h", name, got, want);
			fail_now("value mismatch");
		end
	endtask

	// --------------------
	// reference model
	// --------------------

	// exponent step, range leave is sticky
	task automatic step_exp(input int delta);
		int e;
		e = int'(ref_exp) + delta;
		if (e > EMAX || e < EMIN)
			ref_ovf = 1'b1;
		ref_exp = e[EW-1:0];
	endtask

	// shift left until the top two bits differ
	task automatic normalize_expected();
		if (ref_mant == '0) begin
			ref_exp = '0;
		end else begin
			while (ref_mant[MW-1] == ref_mant[MW-2]) begin
				ref_mant = ref_mant <<< 1;
				step_exp(-1);
			end
		end
	endtask

	task automatic combine_expected(input logic sub, input logic [MW-1:0] m_in,
			input logic [EW-1:0] e_in);
		logic signed [MW-1:0] opm;
		logic signed [EW-1:0] ope;
		longint s;
		opm = m_in;
		ope = e_in;
		// smaller exponent side moves one bit per step
		while (ope != ref_exp) begin
			if (ref_exp < ope) begin
				if (int'(ope) - int'(ref_exp) > MW - 1) begin
					ref_mant = '0;
					ref_exp = ope;
				end else begin
					ref_mant = ref_mant >>> 1;
					step_exp(1);
				end
			end else begin
				if (int'(ref_exp) - int'(ope) > MW - 1) begin
					opm = '0;
					ope = ref_exp;
				end else begin
					opm = opm >>> 1;
					ope = EW'(int'(ope) + 1);
				end
			end
		end
		s = sub ? longint'(ref_mant) - longint'(opm) : longint'(ref_mant) + longint'(opm);
		// sum out of fraction range
		// one place down with the true sign
		if (s > MMAX || s < MMIN) begin
			s = s >>> 1;
			step_exp(1);
		end
		ref_mant = s[MW-1:0];
	endtask

	// --------------------
	// stimulus helpers
	// --------------------

	// three words, low byte and exponent share word 2
	task automatic place_operand(input logic [AW-1:0] base, input logic [MW-1:0] m_in,
			input logic [EW-1:0] e_in);
		fpu_pkg::fp_word_u w;
		mem[base[7:0]] = m_in[MW-1 -: 16];
		mem[base[7:0] + 8'd1] = m_in[MW-17 -: 16];
		w.w2.m_lo = m_in[7:0];
		w.w2.exp = e_in;
		mem[base[7:0] + 8'd2] = w.raw;
	endtask

	task automatic run_operation(input fpu_pkg::fp_op_e code, input logic [MW-1:0] m_in,
			input logic [EW-1:0] e_in);
		logic [AW-1:0] base;
		int waited;
		base = next_addr;
		if (code != fpu_pkg::OP_NORM) begin
			place_operand(base, m_in, e_in);
			next_addr = next_addr + AW'(3);
		end
		// expected result
		ref_ovf = 1'b0;
		case (code)
			fpu_pkg::OP_LOAD: begin
				ref_mant = m_in;
				ref_exp = e_in;
			end
			fpu_pkg::OP_ADD:
				combine_expected(1'b0, m_in, e_in);
			fpu_pkg::OP_SUB:
				combine_expected(1'b1, m_in, e_in);
			default: begin
			end
		endcase
		normalize_expected();
		addr_log.delete();
		// one cycle of efp, op and addr held until done
		@(negedge got_fp);
		op = code;
		addr = base;
		efp = 1'b1;
		@(negedge got_fp);
		efp = 1'b0;
		check_val("busy", 64'(busy), 64'd1);
		waited = 0;
		while (!ekc_fp) begin
			@(negedge got_fp);
			waited++;
			if (waited > OP_CYCLES)
				fail_now("no done pulse, operation did not finish in time");
		end
		// done cycle
		check_val("busy", 64'(busy), 64'd0);
		check_val("acc_mant", 64'(acc_mant), 64'($unsigned(ref_mant)));
		check_val("acc_exp", 64'(acc_exp), 64'($unsigned(ref_exp)));
		check_val("ovf", 64'(ovf), 64'(ref_ovf));
		@(negedge got_fp);
		check_val("ekc_fp", 64'(ekc_fp), 64'd0);
		if (code == fpu_pkg::OP_NORM) begin
			check_val("read_fp count", 64'(addr_log.size()), 64'd0);
		end else begin
			check_val("read_fp count", 64'(addr_log.size()), 64'd3);
			for (int i = 0; i < 3; i++)
				check_val("mem_addr", 64'(addr_log[i]), 64'(base + AW'(i)));
		end
	endtask

	// --------------------
	// tests
	// --------------------

	task automatic reset_values();
		@(negedge got_fp);
		check_val("busy", 64'(busy), 64'd0);
		check_val("read_fp", 64'(read_fp), 64'd0);
		check_val("ekc_fp", 64'(ekc_fp), 64'd0);
		check_val("ovf", 64'(ovf), 64'd0);
		check_val("acc_mant", 64'(acc_mant), 64'd0);
		check_val("acc_exp", 64'(acc_exp), 64'd0);
	endtask

	task automatic load_cases();
		run_operation(fpu_pkg::OP_LOAD, 40'h00_1234_5678, 8'sd5);
		run_operation(fpu_pkg::OP_LOAD, 40'hff_f000_0001, -8'sd3);
		// zero operand ends with exponent 0
		run_operation(fpu_pkg::OP_LOAD, 40'h00_0000_0000, 8'sd34);
		run_operation(fpu_pkg::OP_LOAD, 40'h40_0000_0000, -8'sd7);
	endtask

	task automatic add_cases();
		// equal exponents
		run_operation(fpu_pkg::OP_LOAD, 40'h48_0000_0000, 8'sd3);
		run_operation(fpu_pkg::OP_ADD, 40'h10_0000_0000, 8'sd3);
		// operand far below, dropped
		run_operation(fpu_pkg::OP_LOAD, 40'h50_0000_0000, 8'sd60);
		run_operation(fpu_pkg::OP_ADD, 40'h70_0000_0000, 8'sd2);
		// accumulator far below, dropped
		run_operation(fpu_pkg::OP_LOAD, 40'h40_0000_0000, -8'sd50);
		run_operation(fpu_pkg::OP_ADD, 40'h60_0000_0000, 8'sd10);
		// mantissa overflow
		run_operation(fpu_pkg::OP_LOAD, 40'h60_0000_0000, 8'sd4);
		run_operation(fpu_pkg::OP_ADD, 40'h40_0000_0000, 8'sd4);
		// short alignment on either side
		run_operation(fpu_pkg::OP_LOAD, 40'h40_0000_0000, 8'sd1);
		run_operation(fpu_pkg::OP_ADD, 40'h50_0000_0000, 8'sd4);
		run_operation(fpu_pkg::OP_ADD, 40'hb0_0000_0000, -8'sd2);
	endtask

	task automatic sub_cases();
		// cancellation, long normalize
		run_operation(fpu_pkg::OP_LOAD, 40'h40_0000_0001, 8'sd10);
		run_operation(fpu_pkg::OP_SUB, 40'h40_0000_0000, 8'sd10);
		// exact zero
		run_operation(fpu_pkg::OP_LOAD, 40'h5a_5a5a_5a5a, 8'sd20);
		run_operation(fpu_pkg::OP_SUB, 40'h5a_5a5a_5a5a, 8'sd20);
		// negative result from zero
		run_operation(fpu_pkg::OP_SUB, 40'h40_0000_0000, 8'sd0);
	endtask

	task automatic norm_and_ovf();
		run_operation(fpu_pkg::OP_NORM, '0, '0);
		// normalize runs below the range
		run_operation(fpu_pkg::OP_LOAD, 40'h00_0000_0001, -8'sd123);
		// flag holds while idle
		repeat (5) begin
			@(negedge got_fp);
			check_val("ovf", 64'(ovf), 64'd1);
		end
		run_operation(fpu_pkg::OP_NORM, '0, '0);
		// sum overflow at the top exponent
		run_operation(fpu_pkg::OP_LOAD, 40'h60_0000_0000, 8'sd127);
		run_operation(fpu_pkg::OP_ADD, 40'h40_0000_0000, 8'sd127);
		run_operation(fpu_pkg::OP_LOAD, 40'h00_0000_0000, 8'sd9);
		run_operation(fpu_pkg::OP_NORM, '0, '0);
	endtask

	task automatic slow_memory();
		fixed_delay = 4;
		run_operation(fpu_pkg::OP_LOAD, 40'h33_3333_3333, -8'sd1);
		run_operation(fpu_pkg::OP_ADD, 40'h22_2222_2222, 8'sd1);
		run_operation(fpu_pkg::OP_SUB, 40'h11_1111_1111, 8'sd0);
		fixed_delay = 0;
	endtask

	// --------------------
	// memory model
	// --------------------

	initial begin : memory_model
		int unsigned wait_cycles;
		logic [AW-1:0] req_addr;
		void'($urandom(32'hc45e_a619));
		ok = 1'b0;
		mem_data.raw = '0;
		// background from the whole word address
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = 16'(i) ^ 16'hc3a5;
		forever begin
			@(negedge got_fp);
			ok = 1'b0;
			if (!_0_f && read_fp) begin
				req_addr = mem_addr;
				if (fixed_delay != 0)
					wait_cycles = fixed_delay;
				else
					wait_cycles = $urandom_range(4, 1);
				// request and address must hold until ok
				repeat (wait_cycles - 1) begin
					@(negedge got_fp);
					if (!read_fp || mem_addr != req_addr)
						fail_now("read request dropped or address moved before ok");
				end
				mem_data.raw = mem[req_addr[7:0]];
				ok = 1'b1;
				addr_log.push_back(req_addr);
			end
		end
	end

	// --------------------
	// main sequence
	// --------------------

	initial begin : run_tests
		_0_f = 1'b1;
		efp = 1'b0;
		op = fpu_pkg::OP_LOAD;
		addr = '0;
		fixed_delay = 0;
		next_addr = 16'h0010;
		ref_mant = '0;
		ref_exp = '0;
		ref_ovf = 1'b0;
		repeat (RESET_CYCLES) @(negedge got_fp);
		_0_f = 1'b0;
		reset_values();
		load_cases();
		add_cases();
		sub_cases();
		norm_and_ovf();
		slow_memory();
		$display("TESTS PASSED");
		$finish;
	end

	// budget per operation over all operations
	initial begin : watchdog
		repeat (RESET_CYCLES + IDLE_MARGIN + OP_CYCLES * NUM_OPS) @(posedge got_fp);
		fail_now("watchdog timeout, tests ran past their cycle budget");
	end

endmodule
